/* compile.f */
+incdir+include
hw/rv_isa_pkg.sv
hw/ex_pipe_pkg.sv
hw/ex_result_if.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_writeback_merge.sv
hw/ex_stage_top.sv
dv/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_ex_stage -Mdir obj_dir -o tb_ex_stage_sim \
  -f compile.f \
  && ./obj_dir/tb_ex_stage_sim \
  || { echo "Simulation run failed"; exit 1; }

/* dv/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

module tb_ex_stage;

  localparam int          NUM_INSNS  = 400;
  localparam int          BURST_LEN  = 100;           // Issued back to back without stalls
  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] LFSR_SEED  = 32'hb96e7925;
  localparam logic [31:0] LFSR_TAPS  = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

  // Expected output of one instruction
  typedef struct packed {
    logic [`RV_ILEN-1:0]   insn;
    rv_isa_pkg::reg_addr_t rd;
    logic                  we;
    logic [`RV_XLEN-1:0]   result;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   nxt_pc;
    logic                  illegal;
  } expect_t;

  logic                  clk, rst_n;
  logic                  in_valid, in_ready;
  logic [`RV_ILEN-1:0]   in_insn;
  logic [`RV_XLEN-1:0]   in_pc, in_rs1, in_rs2;
  logic                  out_valid, out_ready;
  rv_isa_pkg::reg_addr_t out_rd;
  logic                  out_we, out_redirect, out_illegal;
  logic [`RV_XLEN-1:0]   out_result, out_nxt_pc;

  logic [31:0]           lfsr_state = LFSR_SEED;
  expect_t               exp_q[$];                    // Scoreboard with the oldest entry first
  int                    accept_count = 0;
  int                    issued;

  // Monitor history from the last rising edges
  logic                  acc_d1, acc_d2, rdy_d1, rdy_d2, stall_d1;
  expect_t               hold;

  ex_stage_top DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .in_valid_i     ( in_valid     ),
    .in_ready_o     ( in_ready     ),
    .in_insn_i      ( in_insn      ),
    .in_pc_i        ( in_pc        ),
    .in_rs1_val_i   ( in_rs1       ),
    .in_rs2_val_i   ( in_rs2       ),
    .out_valid_o    ( out_valid    ),
    .out_ready_i    ( out_ready    ),
    .out_rd_o       ( out_rd       ),
    .out_we_o       ( out_we       ),
    .out_result_o   ( out_result   ),
    .out_redirect_o ( out_redirect ),
    .out_nxt_pc_o   ( out_nxt_pc   ),
    .out_illegal_o  ( out_illegal  ) );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic value_error(input string what);
    $display("ERR %0t ns: %s", $time, what);
    abort_run("Simulation stopped because a DUT value was wrong");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      b          = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]};
      if (b)
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic logic is_kept_opcode(input logic [6:0] opc);
    return opc inside {rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_LUI,
                       rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JAL,
                       rv_isa_pkg::OPC_JALR};
  endfunction

  task automatic gen_insn(output logic [`RV_ILEN-1:0] insn, output logic [`RV_XLEN-1:0] pc,
                          output logic [`RV_XLEN-1:0] rs1, output logic [`RV_XLEN-1:0] rs2);
    logic [3:0] kind;
    logic [6:0] opc;
    kind = 4'(rand_bits(4));
    insn = rand_bits(32);
    case (kind)
      4'd0, 4'd1, 4'd2:   opc = rv_isa_pkg::OPC_OP;
      4'd3, 4'd4, 4'd5:   opc = rv_isa_pkg::OPC_OP_IMM;
      4'd6:               opc = rv_isa_pkg::OPC_LUI;
      4'd7:               opc = rv_isa_pkg::OPC_AUIPC;
      4'd8, 4'd9, 4'd10:  opc = rv_isa_pkg::OPC_BRANCH;
      4'd11:              opc = rv_isa_pkg::OPC_JAL;
      4'd12:              opc = rv_isa_pkg::OPC_JALR;
      default:
      begin
        opc = 7'(rand_bits(7));   // Redraw until no unit owns it
        while (is_kept_opcode(opc))
          opc = 7'(rand_bits(7));
      end
    endcase
    insn[6:0] = opc;
    if (rand_bits(3) == 0)
      insn[11:7] = 5'd0;          // Plenty of x0 destinations
    pc  = rand_bits(32) & ~32'd3;
    rs1 = rand_bits(32);
    if (rand_bits(2) == 0)
      rs2 = rs1;                  // Equal operands for BEQ/BGE cases
    else
      rs2 = rand_bits(32);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic predict(input logic [`RV_ILEN-1:0] insn, input logic [`RV_XLEN-1:0] pc,
                         input logic [`RV_XLEN-1:0] rs1, input logic [`RV_XLEN-1:0] rs2,
                         output expect_t e);
    logic [6:0]          opc;
    logic [2:0]          f3;
    logic [4:0]          sh;
    logic                take;
    logic [`RV_XLEN-1:0] imm_i, imm_u, imm_b, imm_j, b, r, fall;
    opc   = insn[6:0];
    f3    = insn[14:12];
    imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
    imm_u = {insn[31:12], 12'h000};
    imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    fall  = pc + `RV_XLEN'(`RV_PC_STEP);
    take  = 1'b0;
    r     = '0;
    e        = '0;
    e.insn   = insn;
    e.rd     = insn[11:7];
    e.nxt_pc = fall;              // Fall-through unless redirected
    case (opc)
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM:
      begin
        b  = (opc == rv_isa_pkg::OPC_OP) ? rs2 : imm_i;
        sh = b[4:0];
        case (f3)
          rv_isa_pkg::ALU_F3_ADD:
            if (opc == rv_isa_pkg::OPC_OP && insn[30])
              r = rs1 - b;
            else
              r = rs1 + b;
          rv_isa_pkg::ALU_F3_SLL:  r = rs1 << sh;
          rv_isa_pkg::ALU_F3_SLT:  r = ($signed(rs1) < $signed(b)) ? `RV_XLEN'(1) : '0;
          rv_isa_pkg::ALU_F3_SLTU: r = (rs1 < b) ? `RV_XLEN'(1) : '0;
          rv_isa_pkg::ALU_F3_XOR:  r = rs1 ^ b;
          rv_isa_pkg::ALU_F3_SR:
            if (insn[30])
              r = $signed(rs1) >>> sh;
            else
              r = rs1 >> sh;
          rv_isa_pkg::ALU_F3_OR:   r = rs1 | b;
          default:                 r = rs1 & b;
        endcase
        e.we     = (e.rd != 5'd0);
        e.result = r;
      end
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
      begin
        e.we     = (e.rd != 5'd0);
        e.result = (opc == rv_isa_pkg::OPC_LUI) ? imm_u : pc + imm_u;
      end
      rv_isa_pkg::OPC_BRANCH:
      begin
        case (f3)
          rv_isa_pkg::BR_F3_BEQ:  take = (rs1 == rs2);
          rv_isa_pkg::BR_F3_BNE:  take = (rs1 != rs2);
          rv_isa_pkg::BR_F3_BLT:  take = ($signed(rs1) < $signed(rs2));
          rv_isa_pkg::BR_F3_BGE:  take = ($signed(rs1) >= $signed(rs2));
          rv_isa_pkg::BR_F3_BLTU: take = (rs1 < rs2);
          rv_isa_pkg::BR_F3_BGEU: take = (rs1 >= rs2);
          default:                take = 1'b0;
        endcase
        e.result   = fall;        // Link value rides along without a write
        e.redirect = take;
        if (take)
          e.nxt_pc = pc + imm_b;
      end
      rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR:
      begin
        e.we       = (e.rd != 5'd0);
        e.result   = fall;
        e.redirect = 1'b1;
        if (opc == rv_isa_pkg::OPC_JAL)
          e.nxt_pc = pc + imm_j;
        else
          e.nxt_pc = (rs1 + imm_i) & ~`RV_XLEN'(1);
      end
      default: e.illegal = 1'b1;
    endcase
  endtask

  task automatic check_output();
    expect_t e;
    if (exp_q.size() == 0)
      abort_run("Output transfer seen with no instruction outstanding");
    else
    begin
      e = exp_q.pop_front();
      assert (out_rd == e.rd)
        else value_error($sformatf("insn %h rd %0d, expected %0d", e.insn, out_rd, e.rd));
      assert (out_we == e.we)
        else value_error($sformatf("insn %h we %0b, expected %0b", e.insn, out_we, e.we));
      assert (out_result == e.result)
        else value_error($sformatf("insn %h result %h, expected %h", e.insn, out_result,
                                   e.result));
      assert (out_redirect == e.redirect)
        else value_error($sformatf("insn %h redirect %0b, expected %0b", e.insn,
                                   out_redirect, e.redirect));
      assert (out_nxt_pc == e.nxt_pc)
        else value_error($sformatf("insn %h nxt_pc %h, expected %h", e.insn, out_nxt_pc,
                                   e.nxt_pc));
      assert (out_illegal == e.illegal)
        else value_error($sformatf("insn %h illegal %0b, expected %0b", e.insn,
                                   out_illegal, e.illegal));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Samples pre-edge values while inputs change on the falling edge
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      assert (!out_valid) else value_error("out_valid high during reset");
      acc_d1   = 1'b0;
      acc_d2   = 1'b0;
      rdy_d1   = 1'b0;
      rdy_d2   = 1'b0;
      stall_d1 = 1'b0;
    end
    else
    begin
      if (rdy_d1 && rdy_d2)       // Two-cycle latency when the output drains
        assert (out_valid == acc_d2)
          else value_error($sformatf("out_valid %0b, expected %0b two cycles after issue",
                                     out_valid, acc_d2));
      if (stall_d1)
        assert (out_valid && out_rd == hold.rd && out_we == hold.we &&
                out_result == hold.result && out_redirect == hold.redirect &&
                out_nxt_pc == hold.nxt_pc && out_illegal == hold.illegal)
          else value_error("outputs changed while out_ready was low");
      assert (in_ready == (!out_valid || out_ready))
        else value_error($sformatf("in_ready %0b with out_valid %0b and out_ready %0b",
                                   in_ready, out_valid, out_ready));
      if (out_valid && out_ready)
        check_output();
      if (in_valid && in_ready)
      begin
        predict(in_insn, in_pc, in_rs1, in_rs2, hold);
        exp_q.push_back(hold);
        accept_count++;
      end
      acc_d2        = acc_d1;
      acc_d1        = in_valid && in_ready;
      rdy_d2        = rdy_d1;
      rdy_d1        = out_ready;
      stall_d1      = out_valid && !out_ready;
      hold.rd       = out_rd;
      hold.we       = out_we;
      hold.result   = out_result;
      hold.redirect = out_redirect;
      hold.nxt_pc   = out_nxt_pc;
      hold.illegal  = out_illegal;
    end
  end

  initial
  begin
    #(NUM_INSNS * 10 * CLK_PERIOD);
    abort_run("Watchdog timeout, the run did not finish in time");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_insn      = '0;
    in_pc        = '0;
    in_rs1       = '0;
    in_rs2       = '0;
    out_ready    = 1'b0;
    issued       = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid && in_ready) else value_error("pipeline not empty after reset");

    while (accept_count < NUM_INSNS)
    begin
      if (accept_count == issued)   // Previous item taken or slot empty
      begin
        if (issued < NUM_INSNS && (issued < BURST_LEN || rand_bits(2) != 0))
        begin
          gen_insn(in_insn, in_pc, in_rs1, in_rs2);
          in_valid = 1'b1;
          issued++;
        end
        else
          in_valid = 1'b0;
      end
      out_ready = (issued <= BURST_LEN) || (rand_bits(2) != 0);
      @(negedge clk);
    end

    // Drain
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    assert (!out_valid) else value_error("out_valid high with nothing outstanding");
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/ex_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

module ex_stage_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Issue side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [`RV_ILEN-1:0]   in_insn_i,
  input  logic [`RV_XLEN-1:0]   in_pc_i,
  input  logic [`RV_XLEN-1:0]   in_rs1_val_i,
  input  logic [`RV_XLEN-1:0]   in_rs2_val_i,

  // Writeback side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output rv_isa_pkg::reg_addr_t out_rd_o,
  output logic                  out_we_o,
  output logic [`RV_XLEN-1:0]   out_result_o,
  output logic                  out_redirect_o,
  output logic [`RV_XLEN-1:0]   out_nxt_pc_o,
  output logic                  out_illegal_o
);

  ex_pipe_pkg::issue_t issue;
  logic                issue_valid;

  ex_result_if alu_res ();
  ex_result_if br_res ();

  assign issue.insn    = in_insn_i;
  assign issue.pc      = in_pc_i;
  assign issue.rs1_val = in_rs1_val_i;
  assign issue.rs2_val = in_rs2_val_i;

  assign in_ready_o  = alu_res.advance;
  assign issue_valid = in_valid_i & in_ready_o;   // Accepted handshake

  ex_alu u_alu (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .issue_i       ( issue       ),
    .issue_valid_i ( issue_valid ),
    .res           ( alu_res     ) );

  ex_branch u_branch (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .issue_i       ( issue       ),
    .issue_valid_i ( issue_valid ),
    .res           ( br_res      ) );

  ex_writeback_merge u_merge (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .alu            ( alu_res        ),
    .br             ( br_res         ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .out_rd_o       ( out_rd_o       ),
    .out_we_o       ( out_we_o       ),
    .out_result_o   ( out_result_o   ),
    .out_redirect_o ( out_redirect_o ),
    .out_nxt_pc_o   ( out_nxt_pc_o   ),
    .out_illegal_o  ( out_illegal_o  ) );

endmodule

`default_nettype wire

/* hw/ex_writeback_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

module ex_writeback_merge (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  ex_result_if.merge            alu,
  ex_result_if.merge            br,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output rv_isa_pkg::reg_addr_t out_rd_o,
  output logic                  out_we_o,
  output logic [`RV_XLEN-1:0]   out_result_o,
  output logic                  out_redirect_o,
  output logic [`RV_XLEN-1:0]   out_nxt_pc_o,
  output logic                  out_illegal_o
);

  logic                  advance;
  logic                  s1_valid;
  rv_isa_pkg::reg_addr_t rd;
  logic                  we, redirect, illegal;
  logic [`RV_XLEN-1:0]   result;

  // Output register empty or being drained
  assign advance     = !out_valid_o || out_ready_i;
  assign alu.advance = advance;
  assign br.advance  = advance;

  assign s1_valid = alu.valid | br.valid;   // Both units load together

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd       = alu.rd;
    we       = 1'b0;
    result   = '0;
    redirect = 1'b0;
    illegal  = 1'b0;
    if (alu.hit)
    begin
      we     = alu.we;
      result = alu.result;
    end
    else if (br.hit)
    begin
      rd       = br.rd;
      we       = br.we;
      result   = br.result;
      redirect = br.redirect;
    end
    else
      illegal = 1'b1;   // No unit claimed it
  end

  // Output register
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      out_valid_o <= 1'b0;
    else if (advance)
      out_valid_o <= s1_valid;
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      out_rd_o       <= rd;
      out_we_o       <= we;
      out_result_o   <= result;
      out_redirect_o <= redirect;
      out_nxt_pc_o   <= br.nxt_pc;   // Fall-through unless redirected
      out_illegal_o  <= illegal;
    end
  end

endmodule

`default_nettype wire

/* hw/ex_branch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

module ex_branch (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ex_pipe_pkg::issue_t issue_i,
  input  logic                issue_valid_i,
  ex_result_if.unit           res
);

  rv_isa_pkg::insn_t      insn;
  rv_isa_pkg::opcode_e    opcode;
  rv_isa_pkg::branch_f3_e br_f3;
  logic [`RV_XLEN-1:0]    rs1, rs2;
  logic [`RV_XLEN-1:0]    imm_i, imm_b, imm_j;
  logic [`RV_XLEN-1:0]    pc_seq, base, offset, sum, target;
  logic                   cond, hit, taken, link, clr_lsb;

  logic                   s1_valid_q, s1_hit_q, s1_we_q, s1_redirect_q;
  rv_isa_pkg::reg_addr_t  s1_rd_q;
  logic [`RV_XLEN-1:0]    s1_link_q, s1_nxt_pc_q;

  assign insn   = issue_i.insn;
  assign opcode = rv_isa_pkg::opcode_e'(insn[6:0]);
  assign br_f3  = rv_isa_pkg::branch_f3_e'(insn[14:12]);
  assign rs1    = issue_i.rs1_val;
  assign rs2    = issue_i.rs2_val;

  // Immediates
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                  insn[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
                  insn[30:21], 1'b0};

  assign pc_seq = issue_i.pc + `RV_XLEN'(`RV_PC_STEP);   // Fall-through and link

  ////////////////////////////////////////////////////////////////////////////
  // Compare and target
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (br_f3)
      rv_isa_pkg::BR_F3_BEQ:  cond = rs1 == rs2;
      rv_isa_pkg::BR_F3_BNE:  cond = rs1 != rs2;
      rv_isa_pkg::BR_F3_BLT:  cond = $signed(rs1) <  $signed(rs2);
      rv_isa_pkg::BR_F3_BGE:  cond = $signed(rs1) >= $signed(rs2);
      rv_isa_pkg::BR_F3_BLTU: cond = rs1 <  rs2;
      rv_isa_pkg::BR_F3_BGEU: cond = rs1 >= rs2;
      default:                cond = 1'b0;   // Unused encodings fall through
    endcase
  end

  always_comb
  begin
    hit     = 1'b1;
    taken   = 1'b0;
    link    = 1'b0;
    clr_lsb = 1'b0;
    base    = issue_i.pc;
    offset  = imm_b;
    case (opcode)
      rv_isa_pkg::OPC_BRANCH: taken = cond;
      rv_isa_pkg::OPC_JAL:
      begin
        taken  = 1'b1;
        link   = 1'b1;
        offset = imm_j;
      end
      rv_isa_pkg::OPC_JALR:
      begin
        taken   = 1'b1;
        link    = 1'b1;
        clr_lsb = 1'b1;
        base    = rs1;   // Register-relative
        offset  = imm_i;
      end
      default: hit = 1'b0;
    endcase
  end

  // One adder serves all three target forms
  assign sum    = base + offset;
  assign target = {sum[`RV_XLEN-1:1], sum[0] & ~clr_lsb};

  // Stage-1 register
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      s1_valid_q <= 1'b0;
    else if (res.advance)
      s1_valid_q <= issue_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (res.advance)
    begin
      s1_hit_q      <= hit;
      s1_rd_q       <= insn[11:7];
      s1_we_q       <= link && (insn[11:7] != '0);
      s1_link_q     <= pc_seq;
      s1_redirect_q <= taken;
      s1_nxt_pc_q   <= taken ? target : pc_seq;
    end
  end

  assign res.valid    = s1_valid_q;
  assign res.hit      = s1_hit_q;
  assign res.rd       = s1_rd_q;
  assign res.we       = s1_we_q;
  assign res.result   = s1_link_q;
  assign res.redirect = s1_redirect_q;
  assign res.nxt_pc   = s1_nxt_pc_q;

endmodule

`default_nettype wire

/* hw/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

module ex_alu (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ex_pipe_pkg::issue_t issue_i,
  input  logic                issue_valid_i,
  ex_result_if.unit           res
);

  rv_isa_pkg::insn_t     insn;
  rv_isa_pkg::opcode_e   opcode;
  rv_isa_pkg::alu_f3_e   funct3;
  ex_pipe_pkg::alu_op_e  alu_op;
  logic [`RV_XLEN-1:0]   imm_i, imm_u;
  logic [`RV_XLEN-1:0]   op_a, op_b, alu_r;
  logic [4:0]            shamt;
  logic                  hit;

  logic                  s1_valid_q, s1_hit_q, s1_we_q;
  rv_isa_pkg::reg_addr_t s1_rd_q;
  logic [`RV_XLEN-1:0]   s1_result_q;

  // funct3 to operation, alt is funct7 bit 5
  function automatic ex_pipe_pkg::alu_op_e f3_to_op(input rv_isa_pkg::alu_f3_e f3,
                                                    input logic alt,
                                                    input logic is_reg);
    case (f3)
      rv_isa_pkg::ALU_F3_ADD:  return (alt && is_reg) ? ex_pipe_pkg::ALU_SUB
                                                      : ex_pipe_pkg::ALU_ADD;
      rv_isa_pkg::ALU_F3_SLL:  return ex_pipe_pkg::ALU_SLL;
      rv_isa_pkg::ALU_F3_SLT:  return ex_pipe_pkg::ALU_SLT;
      rv_isa_pkg::ALU_F3_SLTU: return ex_pipe_pkg::ALU_SLTU;
      rv_isa_pkg::ALU_F3_XOR:  return ex_pipe_pkg::ALU_XOR;
      rv_isa_pkg::ALU_F3_SR:   return alt ? ex_pipe_pkg::ALU_SRA : ex_pipe_pkg::ALU_SRL;
      rv_isa_pkg::ALU_F3_OR:   return ex_pipe_pkg::ALU_OR;
      default:                 return ex_pipe_pkg::ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign insn   = issue_i.insn;
  assign opcode = rv_isa_pkg::opcode_e'(insn[6:0]);
  assign funct3 = rv_isa_pkg::alu_f3_e'(insn[14:12]);
  assign imm_i  = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};   // Also carries shamt
  assign imm_u  = {insn[31:12], 12'b0};

  always_comb
  begin
    hit    = 1'b1;
    alu_op = ex_pipe_pkg::ALU_ADD;
    op_a   = issue_i.rs1_val;
    op_b   = issue_i.rs2_val;
    case (opcode)
      rv_isa_pkg::OPC_OP:     alu_op = f3_to_op(funct3, insn[30], 1'b1);
      rv_isa_pkg::OPC_OP_IMM:
      begin
        alu_op = f3_to_op(funct3, insn[30], 1'b0);
        op_b   = imm_i;
      end
      rv_isa_pkg::OPC_LUI:
      begin
        alu_op = ex_pipe_pkg::ALU_PASS_B;
        op_b   = imm_u;
      end
      rv_isa_pkg::OPC_AUIPC:
      begin
        op_a = issue_i.pc;
        op_b = imm_u;
      end
      default: hit = 1'b0;   // Not an ALU opcode
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  assign shamt = op_b[4:0];

  always_comb
  begin
    case (alu_op)
      ex_pipe_pkg::ALU_SUB:    alu_r = op_a - op_b;
      ex_pipe_pkg::ALU_SLL:    alu_r = op_a << shamt;
      ex_pipe_pkg::ALU_SLT:    alu_r = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ex_pipe_pkg::ALU_SLTU:   alu_r = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ex_pipe_pkg::ALU_XOR:    alu_r = op_a ^ op_b;
      ex_pipe_pkg::ALU_SRL:    alu_r = op_a >> shamt;
      ex_pipe_pkg::ALU_SRA:    alu_r = $signed(op_a) >>> shamt;
      ex_pipe_pkg::ALU_OR:     alu_r = op_a | op_b;
      ex_pipe_pkg::ALU_AND:    alu_r = op_a & op_b;
      ex_pipe_pkg::ALU_PASS_B: alu_r = op_b;
      default:                 alu_r = op_a + op_b;
    endcase
  end

  // Stage-1 register
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      s1_valid_q <= 1'b0;
    else if (res.advance)
      s1_valid_q <= issue_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (res.advance)
    begin
      s1_hit_q    <= hit;
      s1_rd_q     <= insn[11:7];
      s1_we_q     <= hit && (insn[11:7] != '0);   // x0 stays zero
      s1_result_q <= alu_r;
    end
  end

  assign res.valid    = s1_valid_q;
  assign res.hit      = s1_hit_q;
  assign res.rd       = s1_rd_q;
  assign res.we       = s1_we_q;
  assign res.result   = s1_result_q;
  assign res.redirect = 1'b0;   // ALU never changes flow
  assign res.nxt_pc   = '0;

endmodule

`default_nettype wire

/* hw/ex_result_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_ex_defs.svh"

interface ex_result_if;

  logic                  valid;      // Stage-1 entry holds an instruction
  logic                  hit;        // Unit owns this opcode
  rv_isa_pkg::reg_addr_t rd;
  logic                  we;         // Write rd, never for x0
  logic [`RV_XLEN-1:0]   result;
  logic                  redirect;   // Control flow leaves the fall-through
  logic [`RV_XLEN-1:0]   nxt_pc;
  logic                  advance;    // Pipeline moves this cycle

  // Execution unit side
  modport unit (
    output valid, hit, rd, we, result, redirect, nxt_pc,
    input  advance
  );

  // Writeback merge side
  modport merge (
    input  valid, hit, rd, we, result, redirect, nxt_pc,
    output advance
  );

endinterface

`default_nettype wire

/* hw/ex_pipe_pkg.sv */
`default_nettype none

`include "rv_ex_defs.svh"

package ex_pipe_pkg;

  // Internal ALU operation
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10         // LUI
  } alu_op_e;

  // One instruction as handed to both units
  typedef struct packed {
    rv_isa_pkg::insn_t    insn;
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  rs1_val;
    logic [`RV_XLEN-1:0]  rs2_val;
  } issue_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

`include "rv_ex_defs.svh"

package rv_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic encoding types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`RV_REG_AW-1:0] reg_addr_t;   // Register index
  typedef logic [`RV_ILEN-1:0]   insn_t;       // Raw instruction word

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes handled by the execute stage
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,   // Register-register ALU
    OPC_OP_IMM = 7'b0010011,   // Register-immediate ALU
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,   // Conditional branches
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    ALU_F3_ADD  = 3'b000,      // ADD or SUB on funct7 bit 5
    ALU_F3_SLL  = 3'b001,
    ALU_F3_SLT  = 3'b010,
    ALU_F3_SLTU = 3'b011,
    ALU_F3_XOR  = 3'b100,
    ALU_F3_SR   = 3'b101,      // SRL or SRA on funct7 bit 5
    ALU_F3_OR   = 3'b110,
    ALU_F3_AND  = 3'b111
  } alu_f3_e;

  // funct3 of BRANCH, 010 and 011 are unused
  typedef enum logic [2:0] {
    BR_F3_BEQ  = 3'b000,
    BR_F3_BNE  = 3'b001,
    BR_F3_BLT  = 3'b100,
    BR_F3_BGE  = 3'b101,
    BR_F3_BLTU = 3'b110,
    BR_F3_BGEU = 3'b111
  } branch_f3_e;

endpackage

`default_nettype wire

/* include/rv_ex_defs.svh */
`ifndef RV_EX_DEFS_SVH
`define RV_EX_DEFS_SVH

// Data and PC width
`define RV_XLEN    32

// Instruction word width
`define RV_ILEN    32

// Register address width, x0..x31
`define RV_REG_AW  5

// Fall-through PC increment
`define RV_PC_STEP 4

`endif
